//--- hw/n64_frontend_cfg.svh
// Front end configuration
`ifndef N64_FRONTEND_CFG_SVH
`define N64_FRONTEND_CFG_SVH

// ====================
// Controller ports
// ====================

// Console controller ports fed from host joysticks
`define N64FE_NUM_PORTS 4

// ====================
// Download indexes
// ====================

// Matched against the low six bits of the host index
`define DL_INDEX_PIFROM  6'd0
`define DL_INDEX_N64CART 6'd1
`define DL_INDEX_GBCART  6'd2

// ====================
// Memory map
// ====================

// RAM byte base of the handheld cartridge image
`define CART_GB_BASE 8388608

`endif

//--- hw/load_pkg.sv
// Download and memory write types
package load_pkg;

	// RAM byte address
	typedef logic [26:0] ram_addr_t;
	typedef logic [31:0] word_t;
	// Boot ROM word address
	typedef logic [9:0]  pif_addr_t;

	// Host download stream, one 16-bit half per strobe
	typedef struct packed {
		logic        download;
		logic [7:0]  index;
		ram_addr_t   addr;
		logic [15:0] data;
		logic        wr;
	} ioctl_req_t;

	typedef struct packed {
		pif_addr_t addr;
		word_t     data;
		logic      en;
	} pifrom_wr_t;

	// Single-cycle request, completion comes back as ram_ready
	typedef struct packed {
		ram_addr_t addr;
		word_t     data;
		logic      req;
	} ram_wr_t;

endpackage

//--- hw/pad_pkg.sv
// Controller path types
package pad_pkg;

	typedef logic [19:0] joy_bits_t;
	// Horizontal axis in the low byte
	typedef logic [15:0] analog_t;
	typedef logic signed [7:0] axis_t;
	typedef logic [15:0] n64_buttons_t;

	// Host joystick bit positions
	localparam int JOY_RIGHT   = 0;
	localparam int JOY_LEFT    = 1;
	localparam int JOY_DOWN    = 2;
	localparam int JOY_UP      = 3;
	localparam int JOY_A       = 4;
	localparam int JOY_B       = 5;
	localparam int JOY_START   = 6;
	localparam int JOY_L       = 7;
	localparam int JOY_R       = 8;
	localparam int JOY_Z       = 9;
	localparam int JOY_C_UP    = 10;
	localparam int JOY_C_RIGHT = 11;
	localparam int JOY_C_DOWN  = 12;
	localparam int JOY_C_LEFT  = 13;

	typedef enum logic [2:0] {
		N64PAD = 3'd0,
		NONE   = 3'd1,
		CPAK   = 3'd2,
		RUMBLE = 3'd3,
		SNAC   = 3'd4,
		TPAK   = 3'd5
	} pad_type_e;

	typedef enum logic [1:0] {
		OFF   = 2'd0,
		TO_P2 = 2'd1,
		TO_P3 = 2'd2
	} dual_mode_e;

	// Z bit already resolved for the port
	typedef struct packed {
		joy_bits_t joy;
		analog_t   analog;
	} pad_src_t;

	typedef struct packed {
		n64_buttons_t buttons;
		axis_t        x;
		axis_t        y;
		logic         present;
		logic         pak;
	} pad_state_t;

	// Data is buttons, then x, then y
	typedef struct packed {
		logic          valid;
		logic          absent;
		logic          pak;
		load_pkg::word_t data;
	} poll_resp_t;

endpackage

//--- hw/rom_loader.sv
// Download stream loader
`include "n64_frontend_cfg.svh"

module rom_loader (
	input  logic                 clk_1x,
	input  logic                 RESET,
	input  load_pkg::ioctl_req_t ioctl,
	output logic                 ioctl_wait,
	input  logic                 ram_ready,
	output load_pkg::pifrom_wr_t pifrom_wr,
	output load_pkg::ram_wr_t    ram_wr,
	output logic                 cart_loaded,
	output logic                 romcopy_start,
	output load_pkg::ram_addr_t  romcopy_size
);
	import load_pkg::*;

	logic      download_d;
	logic      pif_active;
	logic      n64_active;
	logic      gb_active;
	logic      n64_end;
	logic      pif_en;
	pif_addr_t pif_addr;
	word_t     pif_data;
	logic      gb_req;
	ram_addr_t gb_addr;
	word_t     gb_data;

	// ====================
	// Index decode
	// ====================

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			download_d <= 1'b0;
			pif_active <= 1'b0;
			n64_active <= 1'b0;
			gb_active  <= 1'b0;
		end else begin
			download_d <= ioctl.download;
			pif_active <= ioctl.download && (ioctl.index[5:0] == `DL_INDEX_PIFROM);
			n64_active <= ioctl.download && (ioctl.index[5:0] == `DL_INDEX_N64CART);
			gb_active  <= ioctl.download && (ioctl.index[5:0] == `DL_INDEX_GBCART);
		end
	end

	// ====================
	// Boot ROM
	// ====================

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			pif_en <= 1'b0;
		end else begin
			pif_en <= pif_active && ioctl.wr && ioctl.addr[1];
		end
	end

	// Byte swap within each half
	always_ff @(posedge clk_1x) begin
		if (pif_active && ioctl.wr) begin
			if (!ioctl.addr[1]) begin
				pif_data[31:24] <= ioctl.data[7:0];
				pif_data[23:16] <= ioctl.data[15:8];
				pif_addr        <= {ioctl.index[6], ioctl.addr[10:2]};
			end else begin
				pif_data[15:8] <= ioctl.data[7:0];
				pif_data[7:0]  <= ioctl.data[15:8];
			end
		end
	end

	assign pifrom_wr = '{addr: pif_addr, data: pif_data, en: pif_en};

	// ====================
	// Handheld cartridge
	// ====================

	// Host stays stalled until the RAM takes the word
	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			gb_req     <= 1'b0;
			ioctl_wait <= 1'b0;
		end else begin
			gb_req <= 1'b0;
			if (!gb_active) begin
				ioctl_wait <= 1'b0;
			end else begin
				if (ioctl.wr && ioctl.addr[1]) begin
					gb_req     <= 1'b1;
					ioctl_wait <= 1'b1;
				end
				if (ram_ready) begin
					ioctl_wait <= 1'b0;
				end
			end
		end
	end

	always_ff @(posedge clk_1x) begin
		if (gb_active && ioctl.wr) begin
			if (!ioctl.addr[1]) begin
				gb_data[15:0] <= ioctl.data;
				gb_addr       <= ioctl.addr + ram_addr_t'(`CART_GB_BASE);
			end else begin
				gb_data[31:16] <= ioctl.data;
			end
		end
	end

	assign ram_wr = '{addr: gb_addr, data: gb_data, req: gb_req};

	// ====================
	// Main cartridge
	// ====================

	assign n64_end = !ioctl.download && download_d && (ioctl.index[5:0] == `DL_INDEX_N64CART);

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			romcopy_start <= 1'b0;
			cart_loaded   <= 1'b0;
		end else begin
			romcopy_start <= n64_end;
			if (pif_active || n64_active || gb_active) begin
				cart_loaded <= 1'b1;
			end
		end
	end

	// Last address of the image is the copy length
	always_ff @(posedge clk_1x) begin
		if (n64_end) begin
			romcopy_size <= ioctl.addr;
		end
	end

	a_wait_has_req: assert property (@(posedge clk_1x) disable iff (!RESET)
		$rose(ioctl_wait) |-> ram_wr.req)
		else $error("Wait rose without a RAM request");

	// Host must hold off while stalled
	a_no_wr_in_wait: assert property (@(posedge clk_1x) disable iff (!RESET)
		ioctl_wait |-> !ioctl.wr)
		else $error("Host write arrived while wait was high");

endmodule

//--- hw/pad_source_select.sv
// Joystick source selector
`include "n64_frontend_cfg.svh"

module pad_source_select (
	input  logic                clk_1x,
	input  logic                RESET,
	input  pad_pkg::joy_bits_t  joy [0:`N64FE_NUM_PORTS-1],
	input  pad_pkg::analog_t    analog [0:`N64FE_NUM_PORTS-1],
	input  pad_pkg::dual_mode_e dual_mode,
	output pad_pkg::pad_src_t   src [0:`N64FE_NUM_PORTS-1]
);
	import pad_pkg::*;

	logic [`N64FE_NUM_PORTS-1:0] z_bit;
	pad_src_t                    src_d [0:`N64FE_NUM_PORTS-1];

	// ====================
	// Z remap
	// ====================

	// Host 0 C-right doubles as Z on a second port
	always_comb begin
		for (int i = 0; i < `N64FE_NUM_PORTS; i++) begin
			z_bit[i] = joy[i][JOY_Z];
		end
		case (dual_mode)
			TO_P2: begin
				z_bit[1] = joy[0][JOY_C_RIGHT];
				z_bit[3] = joy[2][JOY_C_RIGHT];
			end
			TO_P3: begin
				z_bit[2] = joy[0][JOY_C_RIGHT];
				z_bit[3] = joy[1][JOY_C_RIGHT];
			end
			default: ;
		endcase
	end

	always_comb begin
		for (int i = 0; i < `N64FE_NUM_PORTS; i++) begin
			src_d[i].joy        = joy[i];
			src_d[i].joy[JOY_Z] = z_bit[i];
			src_d[i].analog     = analog[i];
		end
	end

	// ====================
	// Input registers
	// ====================

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			for (int i = 0; i < `N64FE_NUM_PORTS; i++) begin
				src[i] <= '0;
			end
		end else begin
			for (int i = 0; i < `N64FE_NUM_PORTS; i++) begin
				src[i] <= src_d[i];
			end
		end
	end

endmodule

//--- hw/pad_mapper.sv
// Controller port mapper
module pad_mapper (
	input  logic                clk_1x,
	input  logic                RESET,
	input  pad_pkg::pad_src_t   src,
	input  pad_pkg::pad_type_e  pad_type,
	output pad_pkg::pad_state_t state
);
	import pad_pkg::*;

	n64_buttons_t buttons;
	axis_t        x_axis;
	axis_t        y_raw;
	axis_t        y_axis;
	logic         present;
	logic         pak;

	// ====================
	// Button order
	// ====================

	// Reserved bits 7:6 stay zero
	assign buttons = {
		src.joy[JOY_A],
		src.joy[JOY_B],
		src.joy[JOY_Z],
		src.joy[JOY_START],
		src.joy[JOY_UP],
		src.joy[JOY_DOWN],
		src.joy[JOY_LEFT],
		src.joy[JOY_RIGHT],
		2'b00,
		src.joy[JOY_L],
		src.joy[JOY_R],
		src.joy[JOY_C_UP],
		src.joy[JOY_C_DOWN],
		src.joy[JOY_C_LEFT],
		src.joy[JOY_C_RIGHT]
	};

	// Console y points up, host y points down
	assign x_axis = axis_t'(src.analog[7:0]);
	assign y_raw  = axis_t'(src.analog[15:8]);
	// Full-scale negative has no positive twin
	assign y_axis = (y_raw == 8'sh80) ? 8'sh7f : -y_raw;

	assign present = (pad_type != NONE);
	assign pak     = (pad_type == CPAK) || (pad_type == RUMBLE) || (pad_type == TPAK);

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			state <= '0;
		end else begin
			state.buttons <= present ? buttons : '0;
			state.x       <= present ? x_axis : '0;
			state.y       <= present ? y_axis : '0;
			state.present <= present;
			state.pak     <= pak;
		end
	end

endmodule

//--- hw/pad_poll_reader.sv
// Controller poll reader
`include "n64_frontend_cfg.svh"

module pad_poll_reader (
	input  logic                clk_1x,
	input  logic                RESET,
	input  pad_pkg::pad_state_t state [0:`N64FE_NUM_PORTS-1],
	input  logic                poll_en,
	input  logic [1:0]          poll_port,
	output pad_pkg::poll_resp_t resp
);
	import load_pkg::*;
	import pad_pkg::*;

	pad_state_t sel;
	word_t      status_word;
	logic       valid_q;
	logic       absent_q;
	logic       pak_q;
	word_t      data_q;

	assign sel         = state[poll_port];
	assign status_word = {sel.buttons, sel.x, sel.y};

	always_ff @(posedge clk_1x) begin
		if (!RESET) begin
			valid_q <= 1'b0;
		end else begin
			valid_q <= poll_en;
		end
	end

	// Response payload held until the next poll
	always_ff @(posedge clk_1x) begin
		if (poll_en) begin
			data_q   <= status_word;
			absent_q <= !sel.present;
			pak_q    <= sel.pak;
		end
	end

	assign resp = '{valid: valid_q, absent: absent_q, pak: pak_q, data: data_q};

	a_poll_answered: assert property (@(posedge clk_1x) disable iff (!RESET)
		poll_en |=> resp.valid)
		else $error("Poll was not answered on the next cycle");

	a_valid_from_poll: assert property (@(posedge clk_1x) disable iff (!RESET)
		resp.valid |-> $past(poll_en))
		else $error("Response valid without a poll");

endmodule

//--- hw/n64_frontend.sv
// Console front end top level
`include "n64_frontend_cfg.svh"

module n64_frontend (
	input  logic                 clk_1x,
	input  logic                 RESET,
	input  load_pkg::ioctl_req_t ioctl,
	output logic                 ioctl_wait,
	input  logic                 ram_ready,
	output load_pkg::pifrom_wr_t pifrom_wr,
	output load_pkg::ram_wr_t    ram_wr,
	output logic                 cart_loaded,
	output logic                 romcopy_start,
	output load_pkg::ram_addr_t  romcopy_size,
	input  pad_pkg::joy_bits_t   joy [0:`N64FE_NUM_PORTS-1],
	input  pad_pkg::analog_t     analog [0:`N64FE_NUM_PORTS-1],
	input  pad_pkg::pad_type_e   pad_type [0:`N64FE_NUM_PORTS-1],
	input  pad_pkg::dual_mode_e  dual_mode,
	input  logic                 poll_en,
	input  logic [1:0]           poll_port,
	output pad_pkg::poll_resp_t  resp
);
	import pad_pkg::*;

	pad_src_t   src [0:`N64FE_NUM_PORTS-1];
	pad_state_t state [0:`N64FE_NUM_PORTS-1];

	// ====================
	// Download path
	// ====================

	rom_loader u_loader (
		.clk_1x        (clk_1x),
		.RESET         (RESET),
		.ioctl         (ioctl),
		.ioctl_wait    (ioctl_wait),
		.ram_ready     (ram_ready),
		.pifrom_wr     (pifrom_wr),
		.ram_wr        (ram_wr),
		.cart_loaded   (cart_loaded),
		.romcopy_start (romcopy_start),
		.romcopy_size  (romcopy_size)
	);

	// ====================
	// Controller path
	// ====================

	pad_source_select u_source (
		.clk_1x    (clk_1x),
		.RESET     (RESET),
		.joy       (joy),
		.analog    (analog),
		.dual_mode (dual_mode),
		.src       (src)
	);

	// One mapper per console port
	for (genvar g = 0; g < `N64FE_NUM_PORTS; g++) begin : g_port
		pad_mapper u_mapper (
			.clk_1x   (clk_1x),
			.RESET    (RESET),
			.src      (src[g]),
			.pad_type (pad_type[g]),
			.state    (state[g])
		);
	end

	pad_poll_reader u_poll (
		.clk_1x    (clk_1x),
		.RESET     (RESET),
		.state     (state),
		.poll_en   (poll_en),
		.poll_port (poll_port),
		.resp      (resp)
	);

endmodule

//--- verif/tb_tests.svh
// Directed front end tests

// ====================
// Stimulus helpers
// ====================

task automatic start_download(input logic [7:0] index);
	ioctl.download = 1'b1;
	ioctl.index    = index;
	ioctl.wr       = 1'b0;
	next_cycle();
endtask

// Index and address stay put so the loader sees the last address
task automatic end_download();
	ioctl.download = 1'b0;
	ioctl.wr       = 1'b0;
	next_cycle();
endtask

task automatic write_half(input ram_addr_t addr, input logic [15:0] data);
	ioctl.addr = addr;
	ioctl.data = data;
	ioctl.wr   = 1'b1;
	next_cycle();
	ioctl.wr = 1'b0;
endtask

// Z source of a port under the current dual mode
function automatic logic resolved_z(input int p);
	logic z;
	z = joy[p][9];
	if (dual_mode == TO_P2) begin
		if (p == 1) z = joy[0][11];
		if (p == 3) z = joy[2][11];
	end else if (dual_mode == TO_P3) begin
		if (p == 2) z = joy[0][11];
		if (p == 3) z = joy[1][11];
	end
	return z;
endfunction

function automatic logic [31:0] expected_pad_word(input int p);
	logic [19:0] j;
	logic [7:0]  v;
	logic [7:0]  y;
	j    = joy[p];
	j[9] = resolved_z(p);
	v    = analog[p][15:8];
	y    = (v == 8'h80) ? 8'h7f : 8'h00 - v;
	if (pad_type[p] == NONE) begin
		return 32'd0;
	end else begin
		return {j[4], j[5], j[9], j[6], j[3], j[2], j[1], j[0], 2'b00,
			j[7], j[8], j[10], j[12], j[13], j[11], analog[p][7:0], y};
	end
endfunction

// Back-to-back polls of every port
task automatic poll_all_ports(input string name);
	logic pak;
	poll_en = 1'b1;
	for (int p = 0; p < `N64FE_NUM_PORTS; p++) begin
		poll_port = 2'(p);
		next_cycle();
		pak = pad_type[p] inside {CPAK, RUMBLE, TPAK};
		check_value({name, " valid"}, 32'd1, 32'(resp.valid));
		check_value({name, " data"}, expected_pad_word(p), resp.data);
		check_value({name, " z"}, 32'((pad_type[p] != NONE) && resolved_z(p)),
			32'(resp.data[29]));
		check_value({name, " absent"}, 32'(pad_type[p] == NONE), 32'(resp.absent));
		check_value({name, " pak"}, 32'(pak), 32'(resp.pak));
	end
	poll_en = 1'b0;
	next_cycle();
	check_value({name, " valid idle"}, 32'd0, 32'(resp.valid));
endtask

// ====================
// Tests
// ====================

task automatic test_reset_state();
	check_value("reset_state pif en", 32'd0, 32'(pifrom_wr.en));
	check_value("reset_state ram req", 32'd0, 32'(ram_wr.req));
	check_value("reset_state wait", 32'd0, 32'(ioctl_wait));
	check_value("reset_state romcopy start", 32'd0, 32'(romcopy_start));
	check_value("reset_state cart loaded", 32'd0, 32'(cart_loaded));
	check_value("reset_state poll valid", 32'd0, 32'(resp.valid));
endtask

task automatic test_pif_load();
	logic [15:0] lo;
	logic [15:0] hi;
	logic [8:0]  waddr;
	ram_addr_t   baddr;
	logic        bank;
	for (int d = 0; d < 2; d++) begin
		bank = d[0];
		start_download({1'b0, bank, 6'd0});
		for (int w = 0; w < 4; w++) begin
			lo    = 16'($urandom());
			hi    = 16'($urandom());
			waddr = 9'($urandom());
			baddr = {16'($urandom()), waddr, 2'b00};
			write_half(baddr, lo);
			check_value("pif_load en after low half", 32'd0, 32'(pifrom_wr.en));
			write_half(baddr | 27'd2, hi);
			check_value("pif_load en", 32'd1, 32'(pifrom_wr.en));
			check_value("pif_load addr", 32'({bank, waddr}), 32'(pifrom_wr.addr));
			check_value("pif_load data", {lo[7:0], lo[15:8], hi[7:0], hi[15:8]},
				pifrom_wr.data);
			next_cycle();
			check_value("pif_load en pulse end", 32'd0, 32'(pifrom_wr.en));
		end
		// Any download marks the cartridge as loaded
		check_value("pif_load cart loaded", 32'd1, 32'(cart_loaded));
		end_download();
	end
endtask

task automatic test_gb_load();
	logic [15:0] lo;
	logic [15:0] hi;
	ram_addr_t   baddr;
	int          cycles;
	start_download(8'd2);
	for (int w = 0; w < 5; w++) begin
		lo    = 16'($urandom());
		hi    = 16'($urandom());
		baddr = ram_addr_t'({22'($urandom()), 2'b00});
		write_half(baddr, lo);
		check_value("gb_load req after low half", 32'd0, 32'(ram_wr.req));
		write_half(baddr | 27'd2, hi);
		check_value("gb_load req", 32'd1, 32'(ram_wr.req));
		check_value("gb_load wait", 32'd1, 32'(ioctl_wait));
		check_value("gb_load addr", 32'(baddr + ram_addr_t'(`CART_GB_BASE)),
			32'(ram_wr.addr));
		check_value("gb_load data", {hi, lo}, ram_wr.data);
		next_cycle();
		cycles = 1;
		check_value("gb_load req pulse end", 32'd0, 32'(ram_wr.req));
		check_value("gb_load wait held", 32'd1, 32'(ioctl_wait));
		while (ioctl_wait) begin
			if (cycles > 12) begin
				$display("SOME TESTS FAILED");
				$fatal(1, "Timed out waiting for the loader to release the host wait");
			end else begin
				next_cycle();
				cycles++;
			end
		end
		check_value("gb_load wait length", 32'(ram_delay + 1), 32'(cycles));
	end
	// Download ends while the host is still stalled
	lo    = 16'($urandom());
	hi    = 16'($urandom());
	baddr = ram_addr_t'({22'($urandom()), 2'b00});
	write_half(baddr, lo);
	write_half(baddr | 27'd2, hi);
	check_value("gb_load last req", 32'd1, 32'(ram_wr.req));
	end_download();
	check_value("gb_load wait at end", 32'd1, 32'(ioctl_wait));
	next_cycle();
	check_value("gb_load wait after end", 32'd0, 32'(ioctl_wait));
endtask

task automatic test_cart_load();
	ram_addr_t baddr;
	ram_addr_t last;
	start_download(8'd1);
	baddr = ram_addr_t'({20'($urandom()), 1'b0});
	for (int w = 0; w < 6; w++) begin
		write_half(baddr + ram_addr_t'(2 * w), 16'($urandom()));
		check_value("cart_load no early start", 32'd0, 32'(romcopy_start));
	end
	last = baddr + 27'd10;
	check_value("cart_load cart loaded", 32'd1, 32'(cart_loaded));
	end_download();
	check_value("cart_load start", 32'd1, 32'(romcopy_start));
	check_value("cart_load size", 32'(last), 32'(romcopy_size));
	for (int c = 0; c < 4; c++) begin
		next_cycle();
		check_value("cart_load single start", 32'd0, 32'(romcopy_start));
	end
	check_value("cart_load stays loaded", 32'd1, 32'(cart_loaded));
endtask

task automatic test_pad_mapping();
	dual_mode = OFF;
	for (int r = 0; r < 3; r++) begin
		for (int p = 0; p < `N64FE_NUM_PORTS; p++) begin
			joy[p]    = joy_bits_t'($urandom());
			analog[p] = analog_t'($urandom());
			case ((r + p) % 3)
				0: pad_type[p] = N64PAD;
				1: pad_type[p] = NONE;
				default: pad_type[p] = CPAK;
			endcase
		end
		// Full-scale negative vertical on one port
		analog[r][15:8] = 8'h80;
		next_cycle();
		next_cycle();
		poll_all_ports("pad_mapping");
	end
endtask

task automatic test_dual_modes();
	for (int m = 0; m < 2; m++) begin
		if (m == 0) begin
			dual_mode = TO_P2;
		end else begin
			dual_mode = TO_P3;
		end
		for (int r = 0; r < 4; r++) begin
			for (int p = 0; p < `N64FE_NUM_PORTS; p++) begin
				joy[p]      = joy_bits_t'($urandom());
				analog[p]   = analog_t'($urandom());
				pad_type[p] = N64PAD;
			end
			next_cycle();
			next_cycle();
			poll_all_ports((m == 0) ? "dual_to_p2" : "dual_to_p3");
		end
	end
	dual_mode = OFF;
endtask

//--- verif/tb_n64_frontend.sv
// Front end testbench
`include "n64_frontend_cfg.svh"

module tb_n64_frontend;
	timeunit 1ns;
	timeprecision 1ps;

	import load_pkg::*;
	import pad_pkg::*;

	logic       clk_1x;
	logic       RESET;
	ioctl_req_t ioctl;
	logic       ioctl_wait;
	logic       ram_ready;
	pifrom_wr_t pifrom_wr;
	ram_wr_t    ram_wr;
	logic       cart_loaded;
	logic       romcopy_start;
	ram_addr_t  romcopy_size;
	joy_bits_t  joy [0:`N64FE_NUM_PORTS-1];
	analog_t    analog [0:`N64FE_NUM_PORTS-1];
	pad_type_e  pad_type [0:`N64FE_NUM_PORTS-1];
	dual_mode_e dual_mode;
	logic       poll_en;
	logic [1:0] poll_port;
	poll_resp_t resp;

	// Latency the RAM model chose for its last request
	int         ram_delay;

	n64_frontend uut (.*);

	initial begin
		clk_1x = 1'b0;
		forever #4 clk_1x = ~clk_1x;
	end

	// Inputs change 1 ns after the edge, outputs are read there too
	task automatic next_cycle();
		@(posedge clk_1x);
		#1;
	endtask

	task automatic check_value(input string name, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			$display("Mismatch in %s: expected %0h, actual %0h", name, expected, actual);
			$display("SOME TESTS FAILED");
			$fatal(1, "Value check failed in %s", name);
		end
	endtask

	// ====================
	// RAM model
	// ====================

	initial begin
		ram_ready = 1'b0;
		ram_delay = 0;
		forever begin
			next_cycle();
			if (ram_wr.req) begin
				ram_delay = $urandom_range(5, 1);
				repeat (ram_delay) next_cycle();
				ram_ready = 1'b1;
				next_cycle();
				ram_ready = 1'b0;
			end
		end
	end

	`include "tb_tests.svh"

	// ====================
	// Run sequence
	// ====================

	initial begin
		void'($urandom(32'h78a9));
		RESET     = 1'b0;
		ioctl     = '0;
		dual_mode = OFF;
		poll_en   = 1'b0;
		poll_port = 2'd0;
		for (int p = 0; p < `N64FE_NUM_PORTS; p++) begin
			joy[p]      = '0;
			analog[p]   = '0;
			pad_type[p] = N64PAD;
		end
		repeat (8) @(posedge clk_1x);
		#1;
		RESET = 1'b1;
		next_cycle();
		test_reset_state();
		test_pif_load();
		test_gb_load();
		test_cart_load();
		test_pad_mapping();
		test_dual_modes();
		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

//--- n64_frontend.f
+incdir+hw
+incdir+verif
hw/load_pkg.sv
hw/pad_pkg.sv
hw/rom_loader.sv
hw/pad_source_select.sv
hw/pad_mapper.sv
hw/pad_poll_reader.sv
hw/n64_frontend.sv
verif/tb_n64_frontend.sv

//--- run_sim.sh
#!/bin/sh
# Compile the front end testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
	--timescale 1ns/1ps \
	--top-module tb_n64_frontend \
	-f n64_frontend.f \
	-o sim_n64_frontend

./obj_dir/sim_n64_frontend
